// File: source/ga_pkg.sv
package ga_pkg;

    // Q5.11 lane format
    localparam int LANE_W    = 16;
    localparam int LANE_FRAC = 11;
    localparam int NUM_LANES = 16;

    // Holds a sum of 16 full-width lane products
    localparam int ACC_W = 40;

    localparam int LANE_MAX   = (2 ** (LANE_W - 1)) - 1;
    localparam int LANE_MIN   = -(2 ** (LANE_W - 1));
    localparam int LANE_ONE   = 2 ** LANE_FRAC;
    localparam int ROUND_HALF = 2 ** (LANE_FRAC - 1);

    typedef logic signed [LANE_W-1:0] ga_lane_t;

    typedef enum logic [3:0] {
        L_SCALAR = 4'd0,
        L_E12    = 4'd1,
        L_E13    = 4'd2,
        L_E23    = 4'd3,
        L_E1O    = 4'd4,
        L_E2O    = 4'd5,
        L_E3O    = 4'd6,
        L_E1I    = 4'd7,
        L_E2I    = 4'd8,
        L_E3I    = 4'd9,
        L_EOI    = 4'd10,
        L_E123O  = 4'd11,
        L_E123I  = 4'd12,
        L_E12OI  = 4'd13,
        L_E13OI  = 4'd14,
        L_E23OI  = 4'd15
    } ga_lane_idx_e;

    // Scalar sits in the top lane
    typedef struct packed {
        ga_lane_t scalar;
        ga_lane_t e12;
        ga_lane_t e13;
        ga_lane_t e23;
        ga_lane_t e1o;
        ga_lane_t e2o;
        ga_lane_t e3o;
        ga_lane_t e1i;
        ga_lane_t e2i;
        ga_lane_t e3i;
        ga_lane_t eoi;
        ga_lane_t e123o;
        ga_lane_t e123i;
        ga_lane_t e12oi;
        ga_lane_t e13oi;
        ga_lane_t e23oi;
    } ga_blades_t;

    // Lane 0 is the leftmost element, so lanes[L_SCALAR] matches blades.scalar
    typedef union packed {
        ga_blades_t                   blades;
        ga_lane_t [0:NUM_LANES-1]     lanes;
    } ga_mv_u;

    typedef enum logic [3:0] {
        GA_FUNCT_ADD   = 4'd0,
        GA_FUNCT_SUB   = 4'd1,
        GA_FUNCT_WEDGE = 4'd3,
        GA_FUNCT_REV   = 4'd6,
        GA_FUNCT_NORM  = 4'd7
    } ga_funct_e;

    typedef struct packed {
        ga_mv_u    a;
        ga_mv_u    b;
        ga_funct_e funct;
    } ga_req_t;

    function automatic ga_lane_t sat_lane(input logic signed [ACC_W-1:0] x);
        ga_lane_t res;
        if (x > LANE_MAX) begin
            res = ga_lane_t'(LANE_MAX);
        end else if (x < LANE_MIN) begin
            res = ga_lane_t'(LANE_MIN);
        end else begin
            res = x[LANE_W-1:0];
        end
        return res;
    endfunction

    // Round half up, then drop the fraction of the product
    function automatic ga_lane_t round_sat_lane(input logic signed [ACC_W-1:0] acc);
        logic signed [ACC_W-1:0] rounded;
        logic signed [ACC_W-1:0] shifted;
        rounded = acc + ROUND_HALF;
        shifted = rounded >>> LANE_FRAC;
        return sat_lane(shifted);
    endfunction

endpackage

// File: source/ga_op_ctrl.sv
module ga_op_ctrl
    import ga_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  ga_mv_u    operand_a_i,
    input  ga_mv_u    operand_b_i,
    input  ga_funct_e operation_i,
    input  logic      valid_i,
    input  ga_mv_u    lane_res_i,
    input  ga_mv_u    wedge_res_i,
    input  ga_lane_t  norm_i,
    output logic      ready_o,
    output logic      valid_o,
    output ga_mv_u    result_o,
    output logic      error_o,
    output ga_req_t   req_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPUTE,
        ST_DONE
    } state_e;

    state_e  state_q;
    state_e  state_d;
    ga_req_t req_q;
    ga_mv_u  norm_mv;
    ga_mv_u  result_d;
    ga_mv_u  result_q;
    logic    error_d;
    logic    error_q;
    logic    accept;

    assign ready_o = (state_q == ST_IDLE);
    assign valid_o = (state_q == ST_DONE);
    assign accept  = ready_o && valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_COMPUTE;
                end
            end
            ST_COMPUTE: state_d = ST_DONE;
            ST_DONE:    state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    // Norm goes to the scalar lane only
    always_comb begin
        norm_mv = '0;
        norm_mv.blades.scalar = norm_i;
    end

    always_comb begin
        result_d = '0;
        error_d  = 1'b0;
        case (req_q.funct)
            GA_FUNCT_ADD,
            GA_FUNCT_SUB,
            GA_FUNCT_REV:   result_d = lane_res_i;
            GA_FUNCT_WEDGE: result_d = wedge_res_i;
            GA_FUNCT_NORM:  result_d = norm_mv;
            default:        error_d  = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= ST_IDLE;
            result_q <= '0;
            error_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_COMPUTE) begin
                result_q <= result_d;
                error_q  <= error_d;
            end
        end
    end

    // Operands held for the whole operation
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q.a     <= operand_a_i;
            req_q.b     <= operand_b_i;
            req_q.funct <= operation_i;
        end
    end

    assign result_o = result_q;
    assign error_o  = error_q;
    assign req_o    = req_q;

    a_single_valid: assert property (
        @(posedge clk_i) disable iff (!rst_ni) valid_o |=> !valid_o
    ) else $error("valid_o high for more than one cycle");

    a_ready_valid_excl: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(ready_o && valid_o)
    ) else $error("ready_o and valid_o high together");

endmodule

// File: source/ga_lane_unit.sv
module ga_lane_unit
    import ga_pkg::*;
(
    input  ga_req_t req_i,
    output ga_mv_u  res_o
);

    ga_mv_u arith;
    ga_mv_u rev;
    logic   is_sub;

    function automatic ga_lane_t add_sat(input ga_lane_t x, input ga_lane_t y,
                                         input logic sub);
        logic signed [ACC_W-1:0] wx;
        logic signed [ACC_W-1:0] wy;
        wx = x;
        wy = y;
        return sat_lane(sub ? (wx - wy) : (wx + wy));
    endfunction

    // -(-32768) clips to 32767
    function automatic ga_lane_t neg_sat(input ga_lane_t x);
        return add_sat('0, x, 1'b1);
    endfunction

    assign is_sub = (req_i.funct == GA_FUNCT_SUB);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            arith.lanes[i] = add_sat(req_i.a.lanes[i], req_i.b.lanes[i], is_sub);
        end
    end

    // Only the bivectors change sign under reversion
    always_comb begin
        rev = req_i.a;
        rev.blades.e12 = neg_sat(req_i.a.blades.e12);
        rev.blades.e13 = neg_sat(req_i.a.blades.e13);
        rev.blades.e23 = neg_sat(req_i.a.blades.e23);
        rev.blades.e1o = neg_sat(req_i.a.blades.e1o);
        rev.blades.e2o = neg_sat(req_i.a.blades.e2o);
        rev.blades.e3o = neg_sat(req_i.a.blades.e3o);
        rev.blades.e1i = neg_sat(req_i.a.blades.e1i);
        rev.blades.e2i = neg_sat(req_i.a.blades.e2i);
        rev.blades.e3i = neg_sat(req_i.a.blades.e3i);
        rev.blades.eoi = neg_sat(req_i.a.blades.eoi);
    end

    assign res_o = (req_i.funct == GA_FUNCT_REV) ? rev : arith;

endmodule

// File: source/ga_wedge_unit.sv
module ga_wedge_unit
    import ga_pkg::*;
(
    input  ga_req_t req_i,
    output ga_mv_u  res_o
);

    ga_lane_t [0:NUM_LANES-1] a;
    ga_lane_t [0:NUM_LANES-1] b;
    logic signed [ACC_W-1:0]  acc [NUM_LANES];
    logic                     a_is_one;

    function automatic logic signed [ACC_W-1:0] mul(input ga_lane_t x, input ga_lane_t y);
        logic signed [ACC_W-1:0] wx;
        logic signed [ACC_W-1:0] wy;
        wx = x;
        wy = y;
        return wx * wy;
    endfunction

    assign a = req_i.a.lanes;
    assign b = req_i.b.lanes;

    always_comb begin
        // Scalar times anything, from either side
        acc[L_SCALAR] = mul(a[L_SCALAR], b[L_SCALAR]);
        for (int i = 1; i < NUM_LANES; i++) begin
            acc[i] = mul(a[L_SCALAR], b[i]) + mul(a[i], b[L_SCALAR]);
        end

        // Bivector pairs that raise to grade 4
        acc[L_E123O] = acc[L_E123O]
                     + mul(a[L_E12], b[L_E3O])
                     - mul(a[L_E13], b[L_E2O])
                     + mul(a[L_E23], b[L_E1O])
                     + mul(a[L_E1O], b[L_E23])
                     - mul(a[L_E2O], b[L_E13])
                     + mul(a[L_E3O], b[L_E12]);

        acc[L_E123I] = acc[L_E123I]
                     + mul(a[L_E12], b[L_E3I])
                     - mul(a[L_E13], b[L_E2I])
                     + mul(a[L_E23], b[L_E1I])
                     + mul(a[L_E1I], b[L_E23])
                     - mul(a[L_E2I], b[L_E13])
                     + mul(a[L_E3I], b[L_E12]);

        acc[L_E12OI] = acc[L_E12OI]
                     + mul(a[L_E12], b[L_EOI])
                     - mul(a[L_E1O], b[L_E2I])
                     + mul(a[L_E2O], b[L_E1I])
                     + mul(a[L_E1I], b[L_E2O])
                     - mul(a[L_E2I], b[L_E1O])
                     + mul(a[L_EOI], b[L_E12]);

        acc[L_E13OI] = acc[L_E13OI]
                     + mul(a[L_E13], b[L_EOI])
                     - mul(a[L_E1O], b[L_E3I])
                     + mul(a[L_E3O], b[L_E1I])
                     + mul(a[L_E1I], b[L_E3O])
                     - mul(a[L_E3I], b[L_E1O])
                     + mul(a[L_EOI], b[L_E13]);

        acc[L_E23OI] = acc[L_E23OI]
                     + mul(a[L_E23], b[L_EOI])
                     - mul(a[L_E2O], b[L_E3I])
                     + mul(a[L_E3O], b[L_E2I])
                     + mul(a[L_E2I], b[L_E3O])
                     - mul(a[L_E3I], b[L_E2O])
                     + mul(a[L_EOI], b[L_E23]);
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            res_o.lanes[i] = round_sat_lane(acc[i]);
        end
    end

    // a = 1.0 is the identity of the wedge through the term table and rounding
    assign a_is_one = (a[L_SCALAR] == LANE_ONE) && (a[1:NUM_LANES-1] == '0);

    always_comb begin
        if (req_i.funct == GA_FUNCT_WEDGE && a_is_one) begin
            a_unit_identity: assert final (res_o.lanes == req_i.b.lanes)
                else $error("wedge with scalar 1.0 does not return b");
        end
    end

endmodule

// File: source/ga_norm_unit.sv
module ga_norm_unit
    import ga_pkg::*;
(
    input  ga_req_t  req_i,
    output ga_lane_t norm_o
);

    logic signed [ACC_W-1:0] sum_sq;
    logic signed [ACC_W-1:0] lane_w;

    // Full-width sum rounded once at the end
    always_comb begin
        sum_sq = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_w = req_i.a.lanes[i];
            sum_sq = sum_sq + lane_w * lane_w;
        end
    end

    assign norm_o = round_sat_lane(sum_sq);

endmodule

// File: source/ga_alu_top.sv
module ga_alu_top
    import ga_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  ga_mv_u    operand_a_i,
    input  ga_mv_u    operand_b_i,
    input  ga_funct_e operation_i,
    input  logic      valid_i,
    output logic      ready_o,
    output ga_mv_u    result_o,
    output logic      valid_o,
    output logic      error_o
);

    ga_req_t  req;
    ga_mv_u   lane_res;
    ga_mv_u   wedge_res;
    ga_lane_t norm;

    ga_op_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .operation_i (operation_i),
        .valid_i     (valid_i),
        .lane_res_i  (lane_res),
        .wedge_res_i (wedge_res),
        .norm_i      (norm),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .error_o     (error_o),
        .req_o       (req)
    );

    // Add, subtract and reverse
    ga_lane_unit u_lane (
        .req_i (req),
        .res_o (lane_res)
    );

    ga_wedge_unit u_wedge (
        .req_i (req),
        .res_o (wedge_res)
    );

    ga_norm_unit u_norm (
        .req_i  (req),
        .norm_o (norm)
    );

endmodule

// File: sim/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 5;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // Release on a falling edge, away from the capture edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: sim/tb_ga_alu.sv
module tb_ga_alu
    import ga_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        ga_mv_u     a;
        ga_mv_u     b;
        logic [3:0] op;
        ga_mv_u     exp_res;
        logic       exp_err;
    } entry_t;

    logic      clk;
    logic      rst_n;
    ga_mv_u    operand_a;
    ga_mv_u    operand_b;
    ga_funct_e operation;
    logic      valid;
    logic      ready;
    ga_mv_u    result;
    logic      res_valid;
    logic      error;

    entry_t table_q[$];
    int     seed   = 32'h31f71c45;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit  = 0;

    tb_clk_gen clk_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    ga_alu_top dut_i (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .operation_i (operation),
        .valid_i     (valid),
        .ready_o     (ready),
        .result_o    (result),
        .valid_o     (res_valid),
        .error_o     (error)
    );

    function automatic ga_lane_t clip_lane(input int v);
        if (v > 32767) begin
            return 16'sh7fff;
        end
        if (v < -32768) begin
            return 16'sh8000;
        end
        return ga_lane_t'(v);
    endfunction

    function automatic ga_mv_u one_lane(input int idx, input ga_lane_t v);
        ga_mv_u mv;
        mv = '0;
        mv.lanes[idx] = v;
        return mv;
    endfunction

    function automatic ga_mv_u random_mv();
        ga_mv_u mv;
        for (int i = 0; i < NUM_LANES; i++) begin
            mv.lanes[i] = ga_lane_t'($random(seed));
        end
        return mv;
    endfunction

    function automatic ga_mv_u lanewise_sum(input ga_mv_u a, input ga_mv_u b, input logic sub);
        ga_mv_u mv;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (sub) begin
                mv.lanes[i] = clip_lane(int'(a.lanes[i]) - int'(b.lanes[i]));
            end else begin
                mv.lanes[i] = clip_lane(int'(a.lanes[i]) + int'(b.lanes[i]));
            end
        end
        return mv;
    endfunction

    // Bivectors are lanes e12 through eoi
    function automatic ga_mv_u reversed(input ga_mv_u a);
        ga_mv_u mv;
        mv = a;
        for (int i = L_E12; i <= L_EOI; i++) begin
            mv.lanes[i] = clip_lane(-int'(a.lanes[i]));
        end
        return mv;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic add_entry(input ga_mv_u a, input ga_mv_u b, input logic [3:0] op,
                             input ga_mv_u exp_res, input logic exp_err);
        table_q.push_back('{a: a, b: b, op: op, exp_res: exp_res, exp_err: exp_err});
    endtask

    task automatic build_table();
        ga_mv_u     a;
        ga_mv_u     b;
        logic [3:0] bad_codes [6] = '{4'd2, 4'd4, 4'd5, 4'd8, 4'd9, 4'd15};
        a = one_lane(L_SCALAR, 16'sh7000);
        add_entry(a, a, GA_FUNCT_ADD, one_lane(L_SCALAR, 16'sh7fff), 1'b0);
        a = one_lane(L_E12, 16'sh8000);
        b = one_lane(L_E12, 16'sh0001);
        add_entry(a, b, GA_FUNCT_SUB, one_lane(L_E12, 16'sh8000), 1'b0);
        for (int k = 0; k < 4; k++) begin
            a = random_mv();
            b = random_mv();
            add_entry(a, b, GA_FUNCT_ADD, lanewise_sum(a, b, 1'b0), 1'b0);
            add_entry(a, b, GA_FUNCT_SUB, lanewise_sum(a, b, 1'b1), 1'b0);
        end
        a = random_mv();
        a.blades.e13 = 16'sh8000;
        add_entry(a, b, GA_FUNCT_REV, reversed(a), 1'b0);
        a = random_mv();
        add_entry(a, b, GA_FUNCT_REV, reversed(a), 1'b0);
        // Norms of 2.0 and 1.25 and one that clips
        a = one_lane(L_SCALAR, 16'sh0800);
        a.lanes[L_E23OI] = 16'sh0800;
        add_entry(a, b, GA_FUNCT_NORM, one_lane(L_SCALAR, 16'sh1000), 1'b0);
        a = one_lane(L_E1O, 16'shf800);
        a.lanes[L_E2I] = 16'sh0400;
        add_entry(a, b, GA_FUNCT_NORM, one_lane(L_SCALAR, 16'sh0a00), 1'b0);
        a = {NUM_LANES{16'h7fff}};
        add_entry(a, b, GA_FUNCT_NORM, one_lane(L_SCALAR, 16'sh7fff), 1'b0);
        b = random_mv();
        add_entry(one_lane(L_SCALAR, 16'sh0800), b, GA_FUNCT_WEDGE, b, 1'b0);
        add_entry(one_lane(L_E12, 16'sh0800), one_lane(L_E3O, 16'sh0800), GA_FUNCT_WEDGE,
                  one_lane(L_E123O, 16'sh0800), 1'b0);
        add_entry(one_lane(L_E13, 16'sh0800), one_lane(L_E2O, 16'sh0800), GA_FUNCT_WEDGE,
                  one_lane(L_E123O, 16'shf800), 1'b0);
        add_entry(one_lane(L_E1O, 16'sh0800), one_lane(L_E2I, 16'sh0800), GA_FUNCT_WEDGE,
                  one_lane(L_E12OI, 16'shf800), 1'b0);
        // Each bad code is followed by an add that must clear the flag
        foreach (bad_codes[k]) begin
            a = random_mv();
            b = random_mv();
            add_entry(a, b, bad_codes[k], '0, 1'b1);
            add_entry(a, b, GA_FUNCT_ADD, lanewise_sum(a, b, 1'b0), 1'b0);
        end
    endtask

    // Starts and ends on a falling edge
    task automatic run_entry(input int idx);
        entry_t e;
        string  tag;
        e         = table_q[idx];
        tag       = $sformatf(" (entry %0d)", idx);
        operand_a = e.a;
        operand_b = e.b;
        operation = ga_funct_e'(e.op);
        valid     = 1'b1;
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
        @(negedge clk);
        valid = 1'b0;
        while (res_valid !== 1'b1) begin
            check_value({"ready_o", tag}, 256'(ready), 256'(1'b0));
            @(negedge clk);
        end
        check_value({"ready_o", tag}, 256'(ready), 256'(1'b0));
        check_value({"result_o", tag}, result, e.exp_res);
        check_value({"error_o", tag}, 256'(error), 256'(e.exp_err));
        @(negedge clk);
        check_value({"valid_o", tag}, 256'(res_valid), 256'(1'b0));
        check_value({"ready_o", tag}, 256'(ready), 256'(1'b1));
    endtask

    initial begin
        operand_a = '0;
        operand_b = '0;
        operation = GA_FUNCT_ADD;
        valid     = 1'b0;
        build_table();
        limit = 20 * table_q.size() + 50;
        @(posedge rst_n);
        @(negedge clk);
        check_value("ready_o after reset", 256'(ready), 256'(1'b1));
        check_value("valid_o after reset", 256'(res_valid), 256'(1'b0));
        check_value("error_o after reset", 256'(error), 256'(1'b0));
        check_value("result_o after reset", result, '0);
        for (int i = 0; i < table_q.size(); i++) begin
            run_entry(i);
        end
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT never answered within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: ga_alu_top.f
source/ga_pkg.sv
source/ga_op_ctrl.sv
source/ga_lane_unit.sv
source/ga_wedge_unit.sv
source/ga_norm_unit.sv
source/ga_alu_top.sv
sim/tb_clk_gen.sv
sim/tb_ga_alu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ga_alu
FLIST     ?= ga_alu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# The log decides the result, so the run status is not used
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
